// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_aes_decipher
FILELIST  = files.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== files.f ====
source/aes_pkg.sv
source/aes_inv_sbox.sv
source/aes_inv_round.sv
source/aes_decipher_ctrl.sv
source/aes_decipher_datapath.sv
source/aes_decipher_block.sv
testbench/tb_aes_decipher.sv

// ==== source/aes_decipher_block.sv ====
/*
  AES inverse cipher core, top level
  Decrypts one block with externally supplied round keys
*/
`timescale 1ns/100ps
`default_nettype none

module aes_decipher_block
  import aes_pkg::*;
#(
  parameter int NUM_ROUNDS_128 = AES128_ROUNDS,
  parameter int NUM_ROUNDS_256 = AES256_ROUNDS
) (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       next,
  input  logic       keylen,
  input  aes_block_t block,
  input  aes_block_t round_key,
  output aes_round_t round,
  output aes_block_t new_block,
  output logic       ready
);

  aes_update_e   op;
  aes_word_idx_t word_sel;

  // Sequencing and handshake
  aes_decipher_ctrl #(
    .NUM_ROUNDS_128 (NUM_ROUNDS_128),
    .NUM_ROUNDS_256 (NUM_ROUNDS_256)
  ) ctrl_i (
    .clk      (clk),
    .reset_n  (reset_n),
    .next     (next),
    .keylen   (keylen),
    .round    (round),
    .ready    (ready),
    .op       (op),
    .word_sel (word_sel)
  );

  // State and round math
  aes_decipher_datapath datapath_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .op        (op),
    .word_sel  (word_sel),
    .block     (block),
    .round_key (round_key),
    .new_block (new_block)
  );

endmodule

`default_nettype wire

// ==== source/aes_decipher_ctrl.sv ====
/*
  AES inverse cipher controller
  Start/done handshake, round-down counter and the S-box
  word counter. Tells the datapath what to do on each edge
*/
`timescale 1ns/100ps
`default_nettype none

module aes_decipher_ctrl
  import aes_pkg::*;
#(
  parameter int NUM_ROUNDS_128 = AES128_ROUNDS,
  parameter int NUM_ROUNDS_256 = AES256_ROUNDS
) (
  input  logic          clk,
  input  logic          reset_n,
  input  logic          next,
  input  logic          keylen,
  output aes_round_t    round,
  output logic          ready,
  output aes_update_e   op,
  output aes_word_idx_t word_sel
);

  typedef enum logic [2:0] {
    CTRL_IDLE,
    CTRL_INIT,
    CTRL_SBOX,
    CTRL_MAIN,
    CTRL_FINAL
  } ctrl_state_e;

  localparam aes_round_t NR_128 = aes_round_t'(NUM_ROUNDS_128);
  localparam aes_round_t NR_256 = aes_round_t'(NUM_ROUNDS_256);

  ctrl_state_e   state_reg, state_next;
  aes_round_t    round_reg, round_next;
  aes_word_idx_t word_reg, word_next;
  logic          ready_reg, ready_next;
  aes_round_t    nr_sel;

  // Round count for the key length, keylen is held while busy
  assign nr_sel = keylen ? NR_256 : NR_128;

  // ------------------------------
  // Next state and counters
  // ------------------------------
  always_comb
  begin
    state_next = state_reg;
    round_next = round_reg;
    word_next  = word_reg;
    ready_next = ready_reg;
    op         = UPD_NONE;
    case (state_reg)
      CTRL_IDLE:
      begin
        // Start counts down from the last round key
        if (next)
        begin
          round_next = nr_sel;
          ready_next = 1'b0;
          state_next = CTRL_INIT;
        end
      end
      CTRL_INIT:
      begin
        op         = UPD_INIT;
        round_next = round_reg - 4'd1;
        word_next  = '0;
        state_next = CTRL_SBOX;
      end
      CTRL_SBOX:
      begin
        // Word counter wraps back to 0 after word 3
        op        = UPD_SBOX;
        word_next = word_reg + 2'd1;
        if (word_reg == 2'd3)
        begin
          state_next = (round_reg == '0) ? CTRL_FINAL : CTRL_MAIN;
        end
      end
      CTRL_MAIN:
      begin
        op         = UPD_MAIN;
        round_next = round_reg - 4'd1;
        state_next = CTRL_SBOX;
      end
      CTRL_FINAL:
      begin
        op         = UPD_FINAL;
        ready_next = 1'b1;
        state_next = CTRL_IDLE;
      end
      default:
      begin
        state_next = CTRL_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state_reg <= CTRL_IDLE;
      round_reg <= '0;
      word_reg  <= '0;
      ready_reg <= 1'b1;
    end
    else
    begin
      state_reg <= state_next;
      round_reg <= round_next;
      word_reg  <= word_next;
      ready_reg <= ready_next;
    end
  end

  assign round    = round_reg;
  assign ready    = ready_reg;
  assign word_sel = word_reg;

  // ------------------------------
  // Checks
  // ------------------------------

  // Also relies on keylen being held stable while busy
  a_round_in_range: assert property (@(posedge clk) disable iff (!reset_n)
    round_reg <= nr_sel)
    else $error("round index above the selected round count");

  // Done flag only while waiting for a start
  a_ready_idle: assert property (@(posedge clk) disable iff (!reset_n)
    (state_reg != CTRL_IDLE) |-> !ready_reg)
    else $error("ready high while a block is in progress");

endmodule

`default_nettype wire

// ==== source/aes_decipher_datapath.sv ====
/*
  AES inverse cipher datapath
  State register with its update select, one word-serial
  inverse S-box and the combinational round logic
*/
`timescale 1ns/100ps
`default_nettype none

module aes_decipher_datapath
  import aes_pkg::*;
(
  input  logic          clk,
  input  logic          reset_n,
  input  aes_update_e   op,
  input  aes_word_idx_t word_sel,
  input  aes_block_t    block,
  input  aes_block_t    round_key,
  output aes_block_t    new_block
);

  aes_state_t  state_reg;
  aes_state_t  state_next;
  aes_state_t  round_out;
  logic [31:0] sbox_in;
  logic [31:0] sbox_out;
  logic        mix_en;

  // ------------------------------
  // Round resources
  // ------------------------------

  // Column picked by the word counter
  assign sbox_in = state_reg.words[word_sel];

  aes_inv_sbox sbox_i (
    .in  (sbox_in),
    .out (sbox_out)
  );

  // Mix in the middle rounds only
  assign mix_en = (op == UPD_MAIN);

  aes_inv_round round_i (
    .state_in  (state_reg),
    .round_key (round_key),
    .mix       (mix_en),
    .state_out (round_out)
  );

  // ------------------------------
  // State update
  // ------------------------------
  always_comb
  begin
    state_next = state_reg;
    case (op)
      // Initial AddRoundKey
      UPD_INIT:  state_next = block ^ round_key;
      // One column through the S-box
      UPD_SBOX:  state_next.words[word_sel] = sbox_out;
      // Round logic output with the mix chosen by op
      UPD_MAIN, UPD_FINAL: state_next = round_out;
      default:   state_next = state_reg;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state_reg <= '0;
    end
    else
    begin
      state_reg <= state_next;
    end
  end

  // Result holds until the next init overwrites it
  assign new_block = state_reg;

  // Controller must always issue a known operation
  a_op_known: assert property (@(posedge clk) disable iff (!reset_n)
    !$isunknown(op))
    else $error("datapath operation is unknown");

endmodule

`default_nettype wire

// ==== source/aes_inv_round.sv ====
/*
  AES inverse round logic
  InvShiftRows, AddRoundKey and, when mix is set, InvMixColumns
  on a full state. Purely combinational
*/
`timescale 1ns/100ps
`default_nettype none

module aes_inv_round
  import aes_pkg::*;
(
  input  aes_state_t state_in,
  input  aes_block_t round_key,
  input  logic       mix,
  output aes_state_t state_out
);

  aes_state_t shifted;
  aes_state_t keyed;
  aes_state_t mixed;

  // ------------------------------
  // InvShiftRows
  // ------------------------------

  // Row r rotates right by r, so s'(r,c) = s(r, c-r mod 4)
  // Row 0 passes through unchanged
  always_comb
  begin
    for (int c = 0; c < 4; c++)
    begin
      for (int r = 0; r < 4; r++)
      begin
        shifted.bytes[4*c + r] = state_in.bytes[4*((c + 4 - r) % 4) + r];
      end
    end
  end

  // AddRoundKey, key bytes share the column-major order of the state
  assign keyed = shifted ^ round_key;

  // ------------------------------
  // InvMixColumns
  // ------------------------------

  // Each column times the 14/11/13/9 circulant matrix
  always_comb
  begin
    for (int c = 0; c < 4; c++)
    begin
      mixed.bytes[4*c]     = gf_mul14(keyed.bytes[4*c])     ^ gf_mul11(keyed.bytes[4*c + 1])
                           ^ gf_mul13(keyed.bytes[4*c + 2]) ^ gf_mul9(keyed.bytes[4*c + 3]);
      mixed.bytes[4*c + 1] = gf_mul9(keyed.bytes[4*c])      ^ gf_mul14(keyed.bytes[4*c + 1])
                           ^ gf_mul11(keyed.bytes[4*c + 2]) ^ gf_mul13(keyed.bytes[4*c + 3]);
      mixed.bytes[4*c + 2] = gf_mul13(keyed.bytes[4*c])     ^ gf_mul9(keyed.bytes[4*c + 1])
                           ^ gf_mul14(keyed.bytes[4*c + 2]) ^ gf_mul11(keyed.bytes[4*c + 3]);
      mixed.bytes[4*c + 3] = gf_mul11(keyed.bytes[4*c])     ^ gf_mul13(keyed.bytes[4*c + 1])
                           ^ gf_mul9(keyed.bytes[4*c + 2])  ^ gf_mul14(keyed.bytes[4*c + 3]);
    end
  end

  // Last round skips the column mix
  assign state_out = mix ? mixed : keyed;

endmodule

`default_nettype wire

// ==== source/aes_inv_sbox.sv ====
/*
  AES inverse S-box, one 32-bit word
  Each byte goes through the same inverse substitution table
*/
`timescale 1ns/100ps
`default_nettype none

module aes_inv_sbox (
  input  logic [31:0] in,
  output logic [31:0] out
);

  // ------------------------------
  // Inverse substitution table
  // ------------------------------

  // Indexed by the input byte, 0x00 first
  localparam logic [7:0] INV_SBOX [0:255] = '{
    8'h52, 8'h09, 8'h6a, 8'hd5, 8'h30, 8'h36, 8'ha5, 8'h38,
    8'hbf, 8'h40, 8'ha3, 8'h9e, 8'h81, 8'hf3, 8'hd7, 8'hfb,
    8'h7c, 8'he3, 8'h39, 8'h82, 8'h9b, 8'h2f, 8'hff, 8'h87,
    8'h34, 8'h8e, 8'h43, 8'h44, 8'hc4, 8'hde, 8'he9, 8'hcb,
    8'h54, 8'h7b, 8'h94, 8'h32, 8'ha6, 8'hc2, 8'h23, 8'h3d,
    8'hee, 8'h4c, 8'h95, 8'h0b, 8'h42, 8'hfa, 8'hc3, 8'h4e,
    8'h08, 8'h2e, 8'ha1, 8'h66, 8'h28, 8'hd9, 8'h24, 8'hb2,
    8'h76, 8'h5b, 8'ha2, 8'h49, 8'h6d, 8'h8b, 8'hd1, 8'h25,
    8'h72, 8'hf8, 8'hf6, 8'h64, 8'h86, 8'h68, 8'h98, 8'h16,
    8'hd4, 8'ha4, 8'h5c, 8'hcc, 8'h5d, 8'h65, 8'hb6, 8'h92,
    8'h6c, 8'h70, 8'h48, 8'h50, 8'hfd, 8'hed, 8'hb9, 8'hda,
    8'h5e, 8'h15, 8'h46, 8'h57, 8'ha7, 8'h8d, 8'h9d, 8'h84,
    8'h90, 8'hd8, 8'hab, 8'h00, 8'h8c, 8'hbc, 8'hd3, 8'h0a,
    8'hf7, 8'he4, 8'h58, 8'h05, 8'hb8, 8'hb3, 8'h45, 8'h06,
    8'hd0, 8'h2c, 8'h1e, 8'h8f, 8'hca, 8'h3f, 8'h0f, 8'h02,
    8'hc1, 8'haf, 8'hbd, 8'h03, 8'h01, 8'h13, 8'h8a, 8'h6b,
    8'h3a, 8'h91, 8'h11, 8'h41, 8'h4f, 8'h67, 8'hdc, 8'hea,
    8'h97, 8'hf2, 8'hcf, 8'hce, 8'hf0, 8'hb4, 8'he6, 8'h73,
    8'h96, 8'hac, 8'h74, 8'h22, 8'he7, 8'had, 8'h35, 8'h85,
    8'he2, 8'hf9, 8'h37, 8'he8, 8'h1c, 8'h75, 8'hdf, 8'h6e,
    8'h47, 8'hf1, 8'h1a, 8'h71, 8'h1d, 8'h29, 8'hc5, 8'h89,
    8'h6f, 8'hb7, 8'h62, 8'h0e, 8'haa, 8'h18, 8'hbe, 8'h1b,
    8'hfc, 8'h56, 8'h3e, 8'h4b, 8'hc6, 8'hd2, 8'h79, 8'h20,
    8'h9a, 8'hdb, 8'hc0, 8'hfe, 8'h78, 8'hcd, 8'h5a, 8'hf4,
    8'h1f, 8'hdd, 8'ha8, 8'h33, 8'h88, 8'h07, 8'hc7, 8'h31,
    8'hb1, 8'h12, 8'h10, 8'h59, 8'h27, 8'h80, 8'hec, 8'h5f,
    8'h60, 8'h51, 8'h7f, 8'ha9, 8'h19, 8'hb5, 8'h4a, 8'h0d,
    8'h2d, 8'he5, 8'h7a, 8'h9f, 8'h93, 8'hc9, 8'h9c, 8'hef,
    8'ha0, 8'he0, 8'h3b, 8'h4d, 8'hae, 8'h2a, 8'hf5, 8'hb0,
    8'hc8, 8'heb, 8'hbb, 8'h3c, 8'h83, 8'h53, 8'h99, 8'h61,
    8'h17, 8'h2b, 8'h04, 8'h7e, 8'hba, 8'h77, 8'hd6, 8'h26,
    8'he1, 8'h69, 8'h14, 8'h63, 8'h55, 8'h21, 8'h0c, 8'h7d
  };

  // ------------------------------
  // Byte lookups
  // ------------------------------

  // Four independent lookups into the one table
  for (genvar i = 0; i < 4; i++)
  begin : g_byte
    assign out[8*i +: 8] = INV_SBOX[in[8*i +: 8]];
  end

endmodule

`default_nettype wire

// ==== source/aes_pkg.sv ====
/*
  AES inverse cipher shared definitions
  State and block types, round counts, the datapath update
  operations and the GF(2^8) multiplies used by InvMixColumns
*/
`default_nettype none

package aes_pkg;

  // ------------------------------
  // Types
  // ------------------------------

  // Cipher state, columns are words and word 0 sits in the top bits
  // Byte index is 4*column + row, so bytes[0] is s(0,0)
  typedef union packed {
    logic [0:3][31:0] words;
    logic [0:15][7:0] bytes;
  } aes_state_t;

  // Block, round key and result
  typedef logic [127:0] aes_block_t;

  // Round key index, wide enough for 14 rounds
  typedef logic [3:0] aes_round_t;

  // Word counter for the S-box pass
  typedef logic [1:0] aes_word_idx_t;

  // What the datapath does with the state on this edge
  typedef enum logic [2:0] {
    UPD_NONE  = 3'd0,
    UPD_INIT  = 3'd1,
    UPD_SBOX  = 3'd2,
    UPD_MAIN  = 3'd3,
    UPD_FINAL = 3'd4
  } aes_update_e;

  // Round counts per key length
  localparam int AES128_ROUNDS = 10;
  localparam int AES256_ROUNDS = 14;

  // ------------------------------
  // GF(2^8) multiplies
  // ------------------------------

  // xtime, reduction polynomial 0x11b
  function automatic logic [7:0] gf_mul2(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (8'h1b & {8{b[7]}});
  endfunction

  // 9 = 8 + 1
  function automatic logic [7:0] gf_mul9(input logic [7:0] b);
    logic [7:0] b8;
    b8 = gf_mul2(gf_mul2(gf_mul2(b)));
    return b8 ^ b;
  endfunction

  // 11 = 8 + 2 + 1
  function automatic logic [7:0] gf_mul11(input logic [7:0] b);
    logic [7:0] b2;
    logic [7:0] b8;
    b2 = gf_mul2(b);
    b8 = gf_mul2(gf_mul2(b2));
    return b8 ^ b2 ^ b;
  endfunction

  // 13 = 8 + 4 + 1
  function automatic logic [7:0] gf_mul13(input logic [7:0] b);
    logic [7:0] b4;
    logic [7:0] b8;
    b4 = gf_mul2(gf_mul2(b));
    b8 = gf_mul2(b4);
    return b8 ^ b4 ^ b;
  endfunction

  // 14 = 8 + 4 + 2
  function automatic logic [7:0] gf_mul14(input logic [7:0] b);
    logic [7:0] b2;
    logic [7:0] b4;
    logic [7:0] b8;
    b2 = gf_mul2(b);
    b4 = gf_mul2(b2);
    b8 = gf_mul2(b4);
    return b8 ^ b4 ^ b2;
  endfunction

endpackage

`default_nettype wire

// ==== testbench/aes_decipher_tests.txt ====
// Header: key length flag (0 AES-128, 1 AES-256), ciphertext, expected plaintext
// Then Nr+1 round keys, round key 0 first
0 69c4e0d86a7b0430d8cdb78070b4c55a 00112233445566778899aabbccddeeff
000102030405060708090a0b0c0d0e0f
d6aa74fdd2af72fadaa678f1d6ab76fe
b692cf0b643dbdf1be9bc5006830b3fe
b6ff744ed2c2c9bf6c590cbf0469bf41
47f7f7bc95353e03f96c32bcfd058dfd
3caaa3e8a99f9deb50f3af57adf622aa
5e390f7df7a69296a7553dc10aa31f6b
14f9701ae35fe28c440adf4d4ea9c026
47438735a41c65b9e016baf4aebf7ad2
549932d1f08557681093ed9cbe2c974e
13111d7fe3944a17f307a78b4d2b30c5
1 8ea2b7ca516745bfeafc49904b496089 00112233445566778899aabbccddeeff
000102030405060708090a0b0c0d0e0f
101112131415161718191a1b1c1d1e1f
a573c29fa176c498a97fce93a572c09c
1651a8cd0244beda1a5da4c10640bade
ae87dff00ff11b68a68ed5fb03fc1567
6de1f1486fa54f9275f8eb5373b8518d
c656827fc9a799176f294cec6cd5598b
3de23a75524775e727bf9eb45407cf39
0bdc905fc27b0948ad5245a4c1871c2f
45f5a66017b2d387300d4d33640a820a
7ccff71cbeb4fe5413e6bbf0d261a7df
f01afafee7a82979d7a5644ab3afe640
2541fe719bf500258813bbd55a721c0a
4e5a6699a9f24fe07e572baacdf8cdea
24fc79ccbf0979e9371ac23c6d68de36

// ==== testbench/tb_aes_decipher.sv ====
/*
  Testbench for the AES inverse cipher core
  Vectors and round keys come from a data file, round keys are
  served by index. Checks result, latency and round sequence
*/
`timescale 1ns/100ps
`default_nettype none

module tb_aes_decipher
  import aes_pkg::*;
();

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 4;
  localparam int NUM_RUNS     = 8;
  localparam int MEM_DEPTH    = 64;
  localparam int MAX_GAP      = 7;
  // Longest run plus gap plus slack, per run
  localparam int RUN_BUDGET   = 5 * AES256_ROUNDS + 1 + MAX_GAP + 10;
  localparam int WATCHDOG_CYCLES = NUM_RUNS * RUN_BUDGET + RESET_CYCLES;

  logic       clk;
  logic       reset_n;
  logic       next;
  logic       keylen;
  aes_block_t block;
  aes_block_t round_key;
  aes_round_t round;
  aes_block_t new_block;
  logic       ready;

  // Test data, one 128-bit word per entry
  aes_block_t  tests_mem [0:MEM_DEPTH-1];
  int          vec_base[$];
  int          key_base;
  logic [5:0]  key_idx;
  logic [31:0] lcg_state;
  aes_block_t  last_result;
  logic        have_result;

  aes_decipher_block dut_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .next      (next),
    .keylen    (keylen),
    .block     (block),
    .round_key (round_key),
    .round     (round),
    .new_block (new_block),
    .ready     (ready)
  );

  // Round key with the index the core asks for, same cycle
  assign key_idx   = 6'(key_base + 3 + int'(round));
  assign round_key = tests_mem[key_idx];

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ------------------------------
  // Helpers
  // ------------------------------

  function automatic aes_block_t mem_word(input int idx);
    return tests_mem[idx[5:0]];
  endfunction

  // LCG, constants from Numerical Recipes
  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int rand_below(input int n);
    return int'((next_random() >> 16) % 32'(n));
  endfunction

  // Round index seen after edge E+k, where E accepts next
  function automatic aes_round_t round_at(input int nr, input int k);
    if (k == 0)
      return aes_round_t'(nr);
    return aes_round_t'(nr - 1 - (k - 1) / 5);
  endfunction

  task automatic abort_run();
    $display("ERRORS FOUND");
    $fatal(1, "stopped at first mismatch");
  endtask

  // ------------------------------
  // Compare tasks
  // ------------------------------

  task automatic check_block(input aes_block_t actual, input aes_block_t expected,
                             input string what);
    if (actual !== expected)
    begin
      $display("error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      abort_run();
    end
  endtask

  task automatic check_round(input aes_round_t actual, input aes_round_t expected,
                             input string what);
    if (actual !== expected)
    begin
      $display("error at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
      abort_run();
    end
  endtask

  task automatic check_flag(input logic actual, input logic expected, input string what);
    if (actual !== expected)
    begin
      $display("error at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
      abort_run();
    end
  endtask

  // ------------------------------
  // One decryption
  // ------------------------------
  task automatic run_vector(input int vidx);
    int         base;
    int         nr;
    int         lat;
    int         gap;
    int         spur_k;
    int         k;
    logic       kl;
    logic       finished;
    aes_block_t cipher;
    aes_block_t plain;
    base   = vec_base[vidx];
    kl     = mem_word(base) != '0;
    cipher = mem_word(base + 1);
    plain  = mem_word(base + 2);
    nr     = kl ? AES256_ROUNDS : AES128_ROUNDS;
    // Init edge plus five edges per round
    lat    = 5 * nr + 1;
    gap    = rand_below(MAX_GAP + 1);
    // Spurious next lands on an edge between E+2 and E+5*Nr
    spur_k = rand_below(5 * nr - 1);
    // Idle gap, old result must hold
    repeat (gap)
    begin
      @(negedge clk);
      check_flag(ready, 1'b1, "ready while idle");
      if (have_result)
        check_block(new_block, last_result, "held result");
    end
    @(posedge clk);
    next     <= 1'b1;
    keylen   <= kl;
    block    <= cipher;
    key_base <= base;
    // Edge E, start taken here
    @(posedge clk);
    next <= 1'b0;
    k = 0;
    finished = 1'b0;
    while (!finished)
    begin
      @(negedge clk);
      check_flag(ready, k >= lat, "ready");
      if (ready)
        finished = 1'b1;
      else
      begin
        check_round(round, round_at(nr, k), "round index");
        if (k == 0 && have_result)
          check_block(new_block, last_result, "result before init");
        @(posedge clk);
        next <= (k == spur_k);
        k++;
      end
    end
    check_block(new_block, plain, kl ? "AES-256 plaintext" : "AES-128 plaintext");
    check_round(round, '0, "round after done");
    last_result = plain;
    have_result = 1'b1;
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial
  begin
    int p;
    int nr;
    int offset;
    reset_n     = 1'b0;
    next        = 1'b0;
    keylen      = 1'b0;
    block       = '0;
    key_base    = 0;
    lcg_state   = 32'h6cfedf70;
    have_result = 1'b0;
    last_result = '0;
    // Fill marks unused entries, never a valid key flag
    for (int i = 0; i < MEM_DEPTH; i++)
      tests_mem[i[5:0]] = {4{32'hffff_0000 | 32'(i)}};
    $readmemh("testbench/aes_decipher_tests.txt", tests_mem);
    // Walk the headers, each vector holds Nr+1 keys
    p = 0;
    while (p < MEM_DEPTH && mem_word(p) <= 128'd1)
    begin
      vec_base.push_back(p);
      nr = (mem_word(p) == 128'd1) ? AES256_ROUNDS : AES128_ROUNDS;
      p = p + 3 + nr + 1;
    end
    if (vec_base.size() == 0)
    begin
      $display("No test vectors found in the data file");
      $display("ERRORS FOUND");
      $fatal(1, "no stimulus");
    end
    repeat (RESET_CYCLES) @(posedge clk);
    reset_n <= 1'b1;
    // Reset values
    @(negedge clk);
    check_flag(ready, 1'b1, "ready after reset");
    check_round(round, '0, "round after reset");
    check_block(new_block, '0, "new_block after reset");
    // Every vector once from a random start, then random picks
    offset = rand_below(vec_base.size());
    for (int r = 0; r < NUM_RUNS; r++)
    begin
      if (r < vec_base.size())
        run_vector((r + offset) % vec_base.size());
      else
        run_vector(rand_below(vec_base.size()));
    end
    $display("NO ERRORS");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Simulation timed out, the core never finished all runs");
    $display("ERRORS FOUND");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire
